/* verilog/debug_pkg.sv */
package debug_pkg;

    ////////////////////
    // widths

    parameter int BYTE_W          = 8;   // uart byte
    parameter int INSTR_W         = 32;  // one instruction word
    parameter int BYTES_PER_INSTR = 4;   // sent low byte first
    parameter int OPCODE_W        = 6;   // opcode field at the top of a word

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [INSTR_W-1:0] instr_t;

    ////////////////////
    // host commands and controller states

    typedef enum logic [2:0]
    {
        cmd_unknown   = 3'd0,  // anything not listed below
        cmd_start     = 3'd1,
        cmd_continous = 3'd2,
        cmd_step_mode = 3'd3,
        cmd_reprogram = 3'd5,
        cmd_step      = 3'd6
    } cmd_e;

    typedef enum logic [2:0]
    {
        st_idle,
        st_programming,
        st_waiting,
        st_step_mode,
        st_continuous,
        st_sending
    } state_e;

    ////////////////////
    // structs between blocks

    typedef struct packed
    {
        logic  valid;  // one cycle per received byte
        byte_t data;   // raw byte
        cmd_e  cmd;    // decoded command
    } rx_event_t;

    typedef struct packed
    {
        logic word_wr;    // a word went to memory this cycle
        logic last_word;  // and it carried the all-ones opcode
    } load_status_t;

endpackage

/* verilog/rx_decoder.sv */
module rx_decoder
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx_done_tick,  // from uart receiver
    input  debug_pkg::byte_t     rx_data,
    output debug_pkg::rx_event_t rx_event
);

    logic            tick_prev;  // done tick, one cycle late
    logic            tick_rise;
    debug_pkg::cmd_e cmd_dec;

    assign tick_rise = rx_done_tick & ~tick_prev;

    // byte to command, unlisted codes fall to unknown
    always_comb
    begin
        case (rx_data)
            debug_pkg::byte_t'(debug_pkg::cmd_start):     cmd_dec = debug_pkg::cmd_start;
            debug_pkg::byte_t'(debug_pkg::cmd_continous): cmd_dec = debug_pkg::cmd_continous;
            debug_pkg::byte_t'(debug_pkg::cmd_step_mode): cmd_dec = debug_pkg::cmd_step_mode;
            debug_pkg::byte_t'(debug_pkg::cmd_reprogram): cmd_dec = debug_pkg::cmd_reprogram;
            debug_pkg::byte_t'(debug_pkg::cmd_step):      cmd_dec = debug_pkg::cmd_step;
            default:                                      cmd_dec = debug_pkg::cmd_unknown;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tick_prev      <= 1'b0;
            rx_event.valid <= 1'b0;
        end
        else
        begin
            tick_prev      <= rx_done_tick;
            rx_event.valid <= tick_rise;  // single cycle per byte
        end

        if (tick_rise)
        begin
            rx_event.data <= rx_data;
            rx_event.cmd  <= cmd_dec;
        end
    end

endmodule

/* verilog/instr_loader.sv */
module instr_loader
#(
    parameter int ADDR_W = 8
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  debug_pkg::rx_event_t    rx_event,
    input  logic                    load_en,     // high while programming
    input  logic                    load_clear,  // start accepted
    output logic                    imem_we,
    output logic [ADDR_W-1:0]       imem_addr,
    output debug_pkg::instr_t       imem_data,
    output debug_pkg::load_status_t load_status
);

    localparam int CNT_W = $clog2(debug_pkg::BYTES_PER_INSTR);

    logic [CNT_W-1:0] byte_cnt;  // lane of the next byte
    logic             accept;
    logic             word_done;

    assign accept    = rx_event.valid & load_en;
    assign word_done = accept && (byte_cnt == CNT_W'(debug_pkg::BYTES_PER_INSTR - 1));

    ////////////////////
    // counters and write strobe

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt  <= '0;
            imem_addr <= '0;
            imem_we   <= 1'b0;
        end
        else
        begin
            imem_we <= word_done;  // one cycle after the fourth byte
            if (load_clear)
            begin
                byte_cnt  <= '0;
                imem_addr <= '0;
            end
            else
            begin
                if (accept)
                    byte_cnt <= byte_cnt + 1'b1;  // wraps after the top lane
                if (imem_we)
                    imem_addr <= imem_addr + 1'b1;  // step past the word just written
            end
        end
    end

    ////////////////////
    // word assembly

    always_ff @(posedge clk)
    begin
        if (accept)
            imem_data[byte_cnt * debug_pkg::BYTE_W +: debug_pkg::BYTE_W] <= rx_event.data;
    end

    // the halt opcode is only recognized here
    assign load_status.word_wr   = imem_we;
    assign load_status.last_word = imem_we &
        (&imem_data[debug_pkg::INSTR_W-1 -: debug_pkg::OPCODE_W]);

endmodule

/* verilog/status_sender.sv */
module status_sender
(
    input  logic             clk,
    input  logic             reset,
    input  logic             send_req,      // one cycle from the controller
    input  debug_pkg::byte_t pc_byte,       // low byte of the program counter
    input  logic             tx_done_tick,  // from uart transmitter
    output logic             tx_start,
    output debug_pkg::byte_t data_out,
    output logic             send_done
);

    logic done_prev;
    logic done_rise;

    assign done_rise = tx_done_tick & ~done_prev;

    ////////////////////
    // transmit handshake

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done_prev <= 1'b0;
            tx_start  <= 1'b0;
            send_done <= 1'b0;
        end
        else
        begin
            done_prev <= tx_done_tick;
            send_done <= tx_start & done_rise;  // one cycle after the edge
            if (send_req)
                tx_start <= 1'b1;
            else if (done_rise)
                tx_start <= 1'b0;  // transmitter has taken the byte
        end
    end

    // byte stays put for the whole transfer
    always_ff @(posedge clk)
    begin
        if (send_req)
            data_out <= pc_byte;
    end

endmodule

/* verilog/debug_ctrl.sv */
module debug_ctrl
(
    input  logic                    clk,
    input  logic                    reset,
    input  debug_pkg::rx_event_t    rx_event,
    input  debug_pkg::load_status_t load_status,
    input  logic                    halt,       // processor has stopped
    input  logic                    send_done,
    output logic                    load_en,
    output logic                    load_clear,
    output logic                    send_req,
    output logic                    cpu_run,
    output logic                    debug
);

    debug_pkg::state_e state;
    debug_pkg::state_e state_next;
    logic              from_step;   // current report belongs to a step
    logic              start_cmd;
    logic              step_fire;
    logic              halt_fire;
    logic              last_word;

    assign start_cmd = (state == debug_pkg::st_idle) && rx_event.valid &&
                       (rx_event.cmd == debug_pkg::cmd_start);
    assign step_fire = (state == debug_pkg::st_step_mode) && rx_event.valid &&
                       (rx_event.cmd == debug_pkg::cmd_step);
    assign halt_fire = (state == debug_pkg::st_continuous) && halt;
    assign last_word = load_status.word_wr & load_status.last_word;

    ////////////////////
    // outputs

    assign load_en    = (state == debug_pkg::st_programming);
    assign debug      = (state == debug_pkg::st_programming);
    assign load_clear = start_cmd;
    assign send_req   = halt_fire | step_fire;
    // run until halt, or one cycle per step
    assign cpu_run    = ((state == debug_pkg::st_continuous) && !halt) | step_fire;

    ////////////////////
    // next state

    always_comb
    begin
        state_next = state;
        case (state)
            debug_pkg::st_idle:
                if (start_cmd)
                    state_next = debug_pkg::st_programming;
            debug_pkg::st_programming:
                if (last_word)
                    state_next = debug_pkg::st_waiting;  // halt opcode written
            debug_pkg::st_waiting:
                if (rx_event.valid)
                begin
                    case (rx_event.cmd)
                        debug_pkg::cmd_continous: state_next = debug_pkg::st_continuous;
                        debug_pkg::cmd_step_mode: state_next = debug_pkg::st_step_mode;
                        default:                  state_next = debug_pkg::st_idle;
                    endcase
                end
            debug_pkg::st_step_mode:
                if (step_fire)
                    state_next = debug_pkg::st_sending;
            debug_pkg::st_continuous:
                if (halt_fire)
                    state_next = debug_pkg::st_sending;
            debug_pkg::st_sending:
                if (send_done)  // bytes arriving here are dropped
                    state_next = from_step ? debug_pkg::st_step_mode : debug_pkg::st_waiting;
            default:
                state_next = debug_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= debug_pkg::st_idle;
            from_step <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (step_fire)
                from_step <= 1'b1;
            else if (halt_fire)
                from_step <= 1'b0;
        end
    end

endmodule

/* verilog/debug_unit.sv */
module debug_unit
#(
    parameter int ADDR_W = 8  // instruction memory address width
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_done_tick,
    input  debug_pkg::byte_t  rx_data,
    input  logic              tx_done_tick,
    input  logic              halt,
    input  debug_pkg::byte_t  pc_byte,
    output logic              tx_start,
    output debug_pkg::byte_t  data_out,
    output logic              imem_we,
    output logic [ADDR_W-1:0] imem_addr,
    output debug_pkg::instr_t imem_data,
    output logic              cpu_run,
    output logic              debug
);

    debug_pkg::rx_event_t    rx_event;
    debug_pkg::load_status_t load_status;
    logic                    load_en;
    logic                    load_clear;
    logic                    send_req;
    logic                    send_done;

    rx_decoder i_rx_decoder
    (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data      (rx_data),
        .rx_event     (rx_event)
    );

    instr_loader #(.ADDR_W(ADDR_W)) i_instr_loader
    (
        .clk         (clk),
        .reset       (reset),
        .rx_event    (rx_event),
        .load_en     (load_en),
        .load_clear  (load_clear),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .load_status (load_status)
    );

    status_sender i_status_sender
    (
        .clk          (clk),
        .reset        (reset),
        .send_req     (send_req),
        .pc_byte      (pc_byte),
        .tx_done_tick (tx_done_tick),
        .tx_start     (tx_start),
        .data_out     (data_out),
        .send_done    (send_done)
    );

    debug_ctrl i_debug_ctrl
    (
        .clk         (clk),
        .reset       (reset),
        .rx_event    (rx_event),
        .load_status (load_status),
        .halt        (halt),
        .send_done   (send_done),
        .load_en     (load_en),
        .load_clear  (load_clear),
        .send_req    (send_req),
        .cpu_run     (cpu_run),
        .debug       (debug)
    );

endmodule

/* test/debug_unit_sva.sv */
module debug_unit_sva
(
    input logic clk,
    input logic reset,
    input logic cpu_run,
    input logic debug,
    input logic send_req,
    input logic step_fire
);

    int fail_count = 0;  // read by the testbench at the end

    ////////////////////
    // run enable rules

    a_run_vs_debug: assert property (@(posedge clk) disable iff (reset) !(cpu_run && debug))
    else
    begin
        fail_count++;
        $error("cpu_run and debug are high in the same cycle");
    end

    a_step_one_cycle: assert property (@(posedge clk) disable iff (reset) step_fire |=> !cpu_run)
    else
    begin
        fail_count++;
        $error("cpu_run still high in the cycle after a step");
    end

    // report request
    a_send_req_pulse: assert property (@(posedge clk) disable iff (reset) send_req |=> !send_req)
    else
    begin
        fail_count++;
        $error("send_req is wider than one cycle");
    end

endmodule

bind debug_ctrl debug_unit_sva i_debug_unit_sva
(
    .clk       (clk),
    .reset     (reset),
    .cpu_run   (cpu_run),
    .debug     (debug),
    .send_req  (send_req),
    .step_fire (step_fire)
);

/* test/debug_unit_tb.sv */
module debug_unit_tb;

    localparam int ADDR_W      = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int GAP_CYCLES  = 1;  // extra idle cycles after each byte
    localparam int PROG1_WORDS = 6;
    localparam int PROG2_WORDS = 4;
    localparam int NUM_BYTES   = 3 + 1 + 4 * PROG1_WORDS + 2 + 1 + 4 * PROG2_WORDS + 5;
    localparam int NUM_REPORTS = 4;
    localparam int TIMEOUT     = (NUM_BYTES * (3 + GAP_CYCLES) + NUM_REPORTS * 14 + 200)
                                 * CLK_PERIOD;

    typedef struct packed
    {
        logic [ADDR_W-1:0] addr;
        debug_pkg::instr_t data;
    } write_t;

    logic              clk;
    logic              reset;
    logic              rx_done_tick;
    debug_pkg::byte_t  rx_data;
    logic              tx_done_tick;
    logic              halt;
    debug_pkg::byte_t  pc_byte;
    logic              tx_start;
    debug_pkg::byte_t  data_out;
    logic              imem_we;
    logic [ADDR_W-1:0] imem_addr;
    debug_pkg::instr_t imem_data;
    logic              cpu_run;
    logic              debug;

    write_t            exp_writes[$];
    debug_pkg::byte_t  exp_reports[$];
    string             test_name;
    int                run_mode;        // 0 no run, 1 continuous, 2 single step
    logic              debug_ok;
    int                seq_errors;
    int                seed_init;
    int                mon_errors = 0;
    int                wr_idx     = 0;
    int                rpt_idx    = 0;
    int                run_count  = 0;  // cpu_run cycles in step mode
    logic              done_seen  = 1'b0;
    logic              tx_start_q = 1'b0;
    debug_pkg::byte_t  rpt_byte   = '0;

    debug_unit #(.ADDR_W(ADDR_W)) i_dut
    (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data      (rx_data),
        .tx_done_tick (tx_done_tick),
        .halt         (halt),
        .pc_byte      (pc_byte),
        .tx_start     (tx_start),
        .data_out     (data_out),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .cpu_run      (cpu_run),
        .debug        (debug)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // assembles low byte first and flags the all-ones opcode
    function automatic logic assemble_word(input debug_pkg::byte_t lane [4],
                                           output debug_pkg::instr_t word);
        word = {lane[3], lane[2], lane[1], lane[0]};
        return &word[31:26];
    endfunction

    ////////////////////
    // host side

    task automatic send_byte(input debug_pkg::byte_t value);
        @(posedge clk);
        #1;
        rx_data      = value;
        rx_done_tick = 1'b1;  // held for two cycles
        repeat (2) @(posedge clk);
        #1;
        rx_done_tick = 1'b0;
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic load_program(input int words);
        debug_pkg::byte_t  lane [4];
        debug_pkg::instr_t word;
        logic              last;
        debug_ok = 1'b1;
        send_byte(debug_pkg::byte_t'(debug_pkg::cmd_start));
        for (int w = 0; w < words; w++)
        begin
            for (int i = 0; i < 4; i++)
                lane[i] = debug_pkg::byte_t'($urandom);
            if (w == words - 1)
                lane[3] = lane[3] | 8'hfc;
            last = assemble_word(lane, word);
            if (last != (w == words - 1))
            begin
                lane[3] = lane[3] ^ 8'h80;  // no halt opcode before the end
                last    = assemble_word(lane, word);
            end
            exp_writes.push_back('{addr: ADDR_W'(w), data: word});
            for (int i = 0; i < 4; i++)
                send_byte(lane[i]);
        end
        while (wr_idx < exp_writes.size())
            @(negedge clk);
        @(negedge clk);
        if (debug !== 1'b0)
        begin
            $display("[ERROR] %s: debug after load expected 0 actual %b", test_name, debug);
            seq_errors++;
        end
        debug_ok = 1'b0;
    endtask

    ////////////////////
    // uart transmitter

    initial
    begin
        int wait_cycles;
        tx_done_tick = 1'b0;
        forever
        begin
            wait (tx_start === 1'b1);
            wait_cycles = 3 + int'($urandom % 8);
            repeat (wait_cycles) @(posedge clk);
            #1;
            tx_done_tick = 1'b1;
            @(posedge clk);
            #1;
            tx_done_tick = 1'b0;
            wait (tx_start === 1'b0);
        end
    end

    ////////////////////
    // comparison

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (imem_we && wr_idx >= exp_writes.size())
            begin
                $display("memory write to address %h when no write was expected", imem_addr);
                mon_errors++;
            end
            else if (imem_we)
            begin
                if (imem_addr !== exp_writes[wr_idx].addr)
                begin
                    $display("[ERROR] %s: write address expected %h actual %h",
                             test_name, exp_writes[wr_idx].addr, imem_addr);
                    mon_errors++;
                end
                if (imem_data !== exp_writes[wr_idx].data)
                begin
                    $display("[ERROR] %s: write data expected %h actual %h",
                             test_name, exp_writes[wr_idx].data, imem_data);
                    mon_errors++;
                end
                if (debug !== 1'b1)
                begin
                    $display("[ERROR] %s: debug expected 1 actual %b", test_name, debug);
                    mon_errors++;
                end
                wr_idx++;
            end
            if (debug === 1'b1 && !debug_ok)
            begin
                $display("[ERROR] %s: debug outside loading expected 0 actual %b",
                         test_name, debug);
                mon_errors++;
            end
            if (cpu_run === 1'b1 && run_mode == 0)
            begin
                $display("[ERROR] %s: cpu_run while stopped expected 0 actual %b",
                         test_name, cpu_run);
                mon_errors++;
            end
            if (cpu_run === 1'b1 && run_mode == 2)
                run_count++;
            if (tx_start && !tx_start_q)
            begin
                done_seen = 1'b0;
                if (rpt_idx < exp_reports.size())
                    rpt_byte = exp_reports[rpt_idx];
                else
                begin
                    $display("status byte sent when no report was expected");
                    mon_errors++;
                    rpt_byte = data_out;
                end
            end
            if (tx_done_tick)
                done_seen = 1'b1;
            if (tx_start && data_out !== rpt_byte)
            begin
                $display("[ERROR] %s: status byte expected %h actual %h",
                         test_name, rpt_byte, data_out);
                mon_errors++;
            end
            if (!tx_start && tx_start_q)
            begin
                if (!done_seen)
                begin
                    $display("tx_start dropped before the transmitter reported done");
                    mon_errors++;
                end
                rpt_idx++;
            end
            tx_start_q = tx_start;
        end
    end

    initial
    begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////
    // test sequence

    initial
    begin
        seed_init    = $urandom(1346);
        reset        = 1'b1;
        rx_done_tick = 1'b0;
        rx_data      = '0;
        halt         = 1'b0;
        pc_byte      = '0;
        run_mode     = 0;
        debug_ok     = 1'b0;
        seq_errors   = 0;
        test_name    = "reset";
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if ({tx_start, imem_we, cpu_run, debug} !== 4'b0000)
        begin
            $display("[ERROR] %s: outputs expected 0000 actual %b",
                     test_name, {tx_start, imem_we, cpu_run, debug});
            seq_errors++;
        end

        test_name = "idle_bytes";
        send_byte(8'h02);
        send_byte(8'h06);
        send_byte(8'ha5);

        test_name = "load_first";
        load_program(PROG1_WORDS);

        test_name = "continuous";
        run_mode  = 1;
        send_byte(debug_pkg::byte_t'(debug_pkg::cmd_continous));
        while (cpu_run !== 1'b1)
            @(negedge clk);
        repeat (8)
        begin
            @(negedge clk);
            if (cpu_run !== 1'b1)
            begin
                $display("[ERROR] %s: cpu_run expected 1 actual %b", test_name, cpu_run);
                seq_errors++;
            end
        end
        @(posedge clk);
        #1;
        pc_byte = debug_pkg::byte_t'($urandom);
        exp_reports.push_back(pc_byte);
        halt     = 1'b1;
        run_mode = 0;
        while (rpt_idx < exp_reports.size())
            @(negedge clk);
        @(posedge clk);
        #1;
        halt = 1'b0;

        test_name = "reprogram";
        send_byte(debug_pkg::byte_t'(debug_pkg::cmd_reprogram));
        load_program(PROG2_WORDS);

        test_name = "single_step";
        run_mode  = 2;
        send_byte(debug_pkg::byte_t'(debug_pkg::cmd_step_mode));
        for (int s = 0; s < 3; s++)
        begin
            @(posedge clk);
            #1;
            pc_byte = debug_pkg::byte_t'($urandom);
            exp_reports.push_back(pc_byte);
            send_byte(debug_pkg::byte_t'(debug_pkg::cmd_step));
            if (s == 0)
                send_byte(debug_pkg::byte_t'(debug_pkg::cmd_step));  // lands while sending
            while (rpt_idx < exp_reports.size())
                @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (run_count != 3)
        begin
            $display("[ERROR] %s: cpu_run cycles expected 3 actual %0d", test_name, run_count);
            seq_errors++;
        end

        $display("errors: sequence %0d, monitor %0d, assertion %0d",
                 seq_errors, mon_errors, i_dut.i_debug_ctrl.i_debug_unit_sva.fail_count);
        if (seq_errors + mon_errors + i_dut.i_debug_ctrl.i_debug_unit_sva.fail_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* vlog.f */
verilog/debug_pkg.sv
verilog/rx_decoder.sv
verilog/instr_loader.sv
verilog/status_sender.sv
verilog/debug_ctrl.sv
verilog/debug_unit.sv
test/debug_unit_sva.sv
test/debug_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = debug_unit_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
